/* pipe_ctrl_defines.svh */
`ifndef PIPE_CTRL_DEFINES_SVH
`define PIPE_CTRL_DEFINES_SVH

// fetch queue entries, power of two from 2 up
`define QUEUE_DEPTH 4

// first fetch address after reset
`define RESET_PC 32'h0000_0200

// architectural register count, sizes the register index
`define NUM_REGS 32

`endif

/* rv32i_types_pkg.sv */
`include "pipe_ctrl_defines.svh"

package rv32i_types_pkg;

    localparam int WORD_W = 32;                 // xlen
    localparam int REG_W  = $clog2(`NUM_REGS);  // 5 bits for 32 regs

    // data or address word
    typedef logic [WORD_W-1:0] word_t;

    // register index, x0 never makes a dependency
    typedef logic [REG_W-1:0] regidx_t;

endpackage

/* pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    // one queued instruction, as fetched
    typedef struct packed {
        rv32i_types_pkg::word_t pc;
        rv32i_types_pkg::word_t insn;
    } fetch_entry_t;

    // execute stage record
    typedef struct packed {
        rv32i_types_pkg::word_t   pc;
        rv32i_types_pkg::regidx_t rs1;
        rv32i_types_pkg::regidx_t rs2;
        rv32i_types_pkg::regidx_t rd;
        logic                     reg_write;
        logic                     dren;     // load
        logic                     dwen;     // store
        logic                     csr_read;
    } ex_payload_t;

    // memory stage record, sources no longer needed
    typedef struct packed {
        rv32i_types_pkg::word_t   pc;
        rv32i_types_pkg::regidx_t rd;
        logic                     reg_write;
        logic                     dren;
        logic                     dwen;
        logic                     csr_read;
    } mem_payload_t;

    // trap report to the privilege unit
    typedef struct packed {
        logic                   fault_insn;
        logic                   mal_insn;
        logic                   illegal_insn;
        logic                   fault_l;
        logic                   mal_l;
        logic                   fault_s;
        logic                   mal_s;
        logic                   breakpoint;
        logic                   env;        // ecall
        rv32i_types_pkg::word_t epc;
        rv32i_types_pkg::word_t badaddr;
    } exc_report_t;

endpackage

/* fetch_pc_unit.sv */
`timescale 1ns/100ps
`include "pipe_ctrl_defines.svh"

module fetch_pc_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pc_en,          // advance or redirect this edge
    input  logic                   npc_sel,        // branch/jump redirect
    input  logic                   insert_priv_pc, // trap or return redirect
    input  rv32i_types_pkg::word_t branch_target,
    input  rv32i_types_pkg::word_t priv_pc,
    output rv32i_types_pkg::word_t pc,
    output logic                   iren
);

    rv32i_types_pkg::word_t next_pc;

    // privilege redirect beats branch, branch beats sequential
    always_comb begin
        if (insert_priv_pc) begin
            next_pc = priv_pc;
        end else if (npc_sel) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc + 32'd4;   // no rv32c, always 4
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (pc_en) begin
            pc <= next_pc;
        end
    end

    // fetch always requests, hazard unit drops unwanted returns
    assign iren = 1'b1;

endmodule

/* fetch_queue.sv */
`timescale 1ns/100ps
`include "pipe_ctrl_defines.svh"

module fetch_queue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wr_en,
    input  logic                        rd_en,
    input  logic                        flush,      // drop everything
    input  pipe_ctrl_pkg::fetch_entry_t wr_entry,
    output pipe_ctrl_pkg::fetch_entry_t rd_entry,   // head, valid with valid_decode
    output logic                        valid_decode,
    output logic                        is_queue_full
);

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    pipe_ctrl_pkg::fetch_entry_t mem [DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [PTR_W:0]              count;     // one extra bit for full
    logic                        do_wr;
    logic                        do_rd;

    assign valid_decode  = (count != '0);
    assign is_queue_full = (count == DEPTH[PTR_W:0]);

    // full refuses writes even with a pop pending
    assign do_wr = wr_en && !is_queue_full;
    assign do_rd = rd_en && valid_decode;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is 2^n
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage, no reset
    always_ff @(posedge clk) begin
        if (do_wr && !flush) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    assign rd_entry = mem[rd_ptr];

endmodule

/* stage_latch.sv */
`timescale 1ns/100ps

module stage_latch #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,     // hold contents
    input  logic     flush,     // load a bubble, beats stall
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;      // bubble
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    // payload only matters while valid
    always_ff @(posedge clk) begin
        if (!stall || flush) begin
            out_data <= in_data;
        end
    end

endmodule

/* stage3_hazard_unit.sv */
`timescale 1ns/100ps

module stage3_hazard_unit (
    input  rv32i_types_pkg::regidx_t  rs1_e,
    input  rv32i_types_pkg::regidx_t  rs2_e,
    input  rv32i_types_pkg::regidx_t  rd_m,
    input  logic                      reg_write,    // mem stage flags
    input  logic                      dren,
    input  logic                      dwen,
    input  logic                      csr_read,
    input  logic                      jump,
    input  logic                      branch,
    input  logic                      mispredict,
    input  logic                      i_mem_busy,
    input  logic                      d_mem_busy,
    input  logic                      ex_busy,
    input  logic                      halt,
    input  logic                      fence_stall,
    input  logic                      ifence,
    input  logic                      fault_insn,
    input  logic                      mal_insn,
    input  logic                      illegal_insn,
    input  logic                      fault_l,
    input  logic                      mal_l,
    input  logic                      fault_s,
    input  logic                      mal_s,
    input  logic                      breakpoint,
    input  logic                      env,
    input  logic                      intr,
    input  logic                      ret,
    input  logic                      insert_pc,
    input  logic                      valid_m,
    input  logic                      valid_e,
    input  logic                      valid_decode,
    input  rv32i_types_pkg::word_t    pc_m,
    input  rv32i_types_pkg::word_t    pc_e,
    input  rv32i_types_pkg::word_t    pc_decode,
    input  rv32i_types_pkg::word_t    pc_f,
    input  rv32i_types_pkg::word_t    badaddr,
    input  logic                      is_queue_full,
    output logic                      pc_en,
    output logic                      npc_sel,
    output logic                      insert_priv_pc,
    output logic                      suppress_iren,
    output logic                      suppress_data,
    output logic                      rollback,
    output logic                      if_ex_stall,
    output logic                      if_ex_flush,
    output logic                      stall_queue,
    output logic                      flush_queue,
    output logic                      ex_mem_stall,
    output logic                      ex_mem_flush,
    output logic                      exc_valid,
    output pipe_ctrl_pkg::exc_report_t exc
);

    logic dmem_access;
    logic branch_jump;
    logic wait_for_imem;
    logic wait_for_dmem;
    logic rs1_match;
    logic rs2_match;
    logic cannot_forward;
    logic mem_use_stall;
    logic exception;
    logic intr_ok;          // interrupt with no exception pending
    logic ex_flush_hazard;
    logic ctrl_hazard;

    // load-use, x0 never matches
    assign rs1_match      = (rs1_e == rd_m) && (rd_m != '0);
    assign rs2_match      = (rs2_e == rd_m) && (rd_m != '0);
    assign cannot_forward = dren || csr_read;   // value only exists after mem
    // bubbles write nothing
    assign mem_use_stall  = valid_m && valid_e && reg_write && cannot_forward
                         && (rs1_match || rs2_match);

    assign dmem_access   = valid_m && (dren || dwen);   // bubble never touches dmem
    assign branch_jump   = jump || (branch && mispredict);
    assign wait_for_imem = i_mem_busy && !suppress_iren;
    assign wait_for_dmem = dmem_access && d_mem_busy && !suppress_data;

    assign exception = fault_insn | mal_insn | illegal_insn
                     | fault_l | mal_l | fault_s | mal_s
                     | breakpoint | env;
    assign intr_ok   = intr && !exception;

    // interrupt lets an outstanding dmem op finish first
    assign ex_flush_hazard = exception
                          || (intr_ok && !wait_for_dmem)
                          || ret
                          || (ifence && !fence_stall);     // refetch after fence
    assign ctrl_hazard     = ex_flush_hazard || branch_jump;

    assign npc_sel        = branch_jump;
    assign insert_priv_pc = insert_pc;
    assign rollback       = ifence && !fence_stall;
    assign suppress_iren  = ctrl_hazard || insert_pc;  // fetch about to be thrown away
    assign suppress_data  = exception;                  // never touch a faulting address

    // mem stage slow stalls everyone
    assign ex_mem_stall = wait_for_dmem || fence_stall || halt;

    // busy execute yields to control hazards
    assign stall_queue = ex_mem_stall
                      || (ex_busy && !ctrl_hazard)
                      || mem_use_stall
                      || fence_stall;

    assign flush_queue  = ctrl_hazard;
    assign ex_mem_flush = ctrl_hazard || (stall_queue && !ex_mem_stall);   // bubble into mem
    assign if_ex_stall  = is_queue_full || fence_stall;
    assign if_ex_flush  = ctrl_hazard || wait_for_imem;   // drop the fetch slot

    // pc moves when fetch can hand off, or on any redirect
    assign pc_en = (!if_ex_stall && !wait_for_imem)
                || branch_jump
                || insert_pc
                || ret;

    assign exc_valid = exception || (intr_ok && !wait_for_dmem);

    always_comb begin
        exc.fault_insn   = fault_insn;
        exc.mal_insn     = mal_insn;
        exc.illegal_insn = illegal_insn;
        exc.fault_l      = fault_l;
        exc.mal_l        = mal_l;
        exc.fault_s      = fault_s;
        exc.mal_s        = mal_s;
        exc.breakpoint   = breakpoint;
        exc.env          = env;
        exc.badaddr      = badaddr;
        // oldest valid insn, mem skipped on interrupt since it completes
        if (valid_m && !intr_ok) begin
            exc.epc = pc_m;
        end else if (valid_e) begin
            exc.epc = pc_e;
        end else if (valid_decode) begin
            exc.epc = pc_decode;
        end else begin
            exc.epc = pc_f;
        end
    end

endmodule

/* pipeline_ctrl_top.sv */
`timescale 1ns/100ps

module pipeline_ctrl_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rv32i_types_pkg::word_t     imem_rdata,     // insn at pc
    input  logic                       i_mem_busy,
    input  logic                       d_mem_busy,
    input  rv32i_types_pkg::regidx_t   rs1_d,          // decoder, queue head
    input  rv32i_types_pkg::regidx_t   rs2_d,
    input  rv32i_types_pkg::regidx_t   rd_d,
    input  logic                       reg_write_d,
    input  logic                       dren_d,
    input  logic                       dwen_d,
    input  logic                       csr_read_d,
    input  logic                       jump,           // execute outcome
    input  logic                       branch,
    input  logic                       mispredict,
    input  rv32i_types_pkg::word_t     branch_target,
    input  logic                       ex_busy,
    input  logic                       halt,
    input  logic                       fence_stall,
    input  logic                       ifence,
    input  logic                       fault_insn,
    input  logic                       mal_insn,
    input  logic                       illegal_insn,
    input  logic                       fault_l,
    input  logic                       mal_l,
    input  logic                       fault_s,
    input  logic                       mal_s,
    input  logic                       breakpoint,
    input  logic                       env,
    input  logic                       intr,           // privilege unit
    input  logic                       ret,
    input  logic                       insert_pc,
    input  rv32i_types_pkg::word_t     priv_pc,
    input  rv32i_types_pkg::word_t     badaddr,
    output rv32i_types_pkg::word_t     pc,
    output logic                       iren,
    output rv32i_types_pkg::word_t     decode_insn,    // to the decoder
    output logic                       valid_decode,
    output logic                       stall_queue,
    output logic                       flush_queue,
    output logic                       ex_mem_stall,
    output logic                       ex_mem_flush,
    output logic                       if_ex_flush,
    output logic                       exc_valid,
    output pipe_ctrl_pkg::exc_report_t exc
);

    logic                         pc_en;
    logic                         npc_sel;
    logic                         insert_priv_pc;
    logic                         if_ex_stall;
    logic                         is_queue_full;
    logic                         q_wr;
    logic                         valid_e;
    logic                         valid_m;
    pipe_ctrl_pkg::fetch_entry_t  q_in;
    pipe_ctrl_pkg::fetch_entry_t  q_head;
    pipe_ctrl_pkg::ex_payload_t   ex_in;
    pipe_ctrl_pkg::ex_payload_t   ex_q;
    pipe_ctrl_pkg::mem_payload_t  mem_in;
    pipe_ctrl_pkg::mem_payload_t  mem_q;

    // take the returned insn unless fetch is stalled or dropped
    assign q_wr        = iren && !i_mem_busy && !if_ex_flush && !if_ex_stall;
    assign q_in.pc     = pc;
    assign q_in.insn   = imem_rdata;
    assign decode_insn = q_head.insn;

    always_comb begin
        ex_in.pc        = q_head.pc;
        ex_in.rs1       = rs1_d;
        ex_in.rs2       = rs2_d;
        ex_in.rd        = rd_d;
        ex_in.reg_write = reg_write_d;
        ex_in.dren      = dren_d;
        ex_in.dwen      = dwen_d;
        ex_in.csr_read  = csr_read_d;
        mem_in.pc        = ex_q.pc;    // sources dropped past execute
        mem_in.rd        = ex_q.rd;
        mem_in.reg_write = ex_q.reg_write;
        mem_in.dren      = ex_q.dren;
        mem_in.dwen      = ex_q.dwen;
        mem_in.csr_read  = ex_q.csr_read;
    end

    fetch_pc_unit fetch_pc_unit_i (
        .clk, .rst_n, .pc_en, .npc_sel, .insert_priv_pc,
        .branch_target, .priv_pc, .pc, .iren
    );

    fetch_queue fetch_queue_i (
        .clk, .rst_n,
        .wr_en(q_wr), .rd_en(valid_decode && !stall_queue), .flush(flush_queue),
        .wr_entry(q_in), .rd_entry(q_head), .valid_decode, .is_queue_full
    );

    stage_latch #(.payload_t(pipe_ctrl_pkg::ex_payload_t)) ex_latch_i (
        .clk, .rst_n, .stall(stall_queue), .flush(flush_queue),
        .in_valid(valid_decode), .in_data(ex_in), .out_valid(valid_e), .out_data(ex_q)
    );

    stage_latch #(.payload_t(pipe_ctrl_pkg::mem_payload_t)) mem_latch_i (
        .clk, .rst_n, .stall(ex_mem_stall), .flush(ex_mem_flush),
        .in_valid(valid_e), .in_data(mem_in), .out_valid(valid_m), .out_data(mem_q)
    );

    stage3_hazard_unit hazard_i (
        .rs1_e(ex_q.rs1), .rs2_e(ex_q.rs2), .rd_m(mem_q.rd),
        .reg_write(mem_q.reg_write), .dren(mem_q.dren), .dwen(mem_q.dwen),
        .csr_read(mem_q.csr_read),
        .jump, .branch, .mispredict, .i_mem_busy, .d_mem_busy, .ex_busy, .halt,
        .fence_stall, .ifence,
        .fault_insn, .mal_insn, .illegal_insn, .fault_l, .mal_l, .fault_s, .mal_s,
        .breakpoint, .env, .intr, .ret, .insert_pc,
        .valid_m, .valid_e, .valid_decode,
        .pc_m(mem_q.pc), .pc_e(ex_q.pc), .pc_decode(q_head.pc), .pc_f(pc),
        .badaddr, .is_queue_full,
        .pc_en, .npc_sel, .insert_priv_pc,
        .suppress_iren(), .suppress_data(), .rollback(),
        .if_ex_stall, .if_ex_flush, .stall_queue, .flush_queue,
        .ex_mem_stall, .ex_mem_flush, .exc_valid, .exc
    );

endmodule

/* tb_pipeline_ctrl_sva.sv */
`timescale 1ns/100ps
`include "pipe_ctrl_defines.svh"

module tb_pipeline_ctrl_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   flush_queue,
    input logic                   stall_queue,
    input logic                   is_queue_full,
    input logic                   valid_decode,
    input logic                   ex_mem_stall,
    input logic                   ex_mem_flush,
    input logic                   if_ex_flush,
    input logic                   exc_valid,
    input rv32i_types_pkg::word_t pc
);

    // a flushed queue must not keep the fetch that is being dropped
    property flush_blocks_write;
        @(posedge clk) disable iff (!rst_n) flush_queue |=> !valid_decode;
    endproperty

    // full queue that pops takes nothing new, so it drops out of full
    property full_blocks_write;
        @(posedge clk) disable iff (!rst_n)
            is_queue_full && !stall_queue && !flush_queue |=> !is_queue_full;
    endproperty

    // control quiet while held in reset
    property reset_state;
        @(posedge clk) !rst_n |-> (pc == `RESET_PC) && !valid_decode && !flush_queue
                                  && !stall_queue && !ex_mem_stall && !ex_mem_flush
                                  && !if_ex_flush && !exc_valid;
    endproperty

    a_flush_blocks_write: assert property (flush_blocks_write)
        else $error("queue written while flushed");
    a_full_blocks_write: assert property (full_blocks_write)
        else $error("queue written while full");
    a_reset_state: assert property (reset_state)
        else $error("control outputs not at reset values");

endmodule

/* tb_pipeline_ctrl.sv */
`timescale 1ns/100ps
`include "pipe_ctrl_defines.svh"

module tb_pipeline_ctrl;

    logic clk;
    logic rst_n;
    logic d_mem_busy, branch, mispredict, fault_l, intr;
    logic reg_write_d, dren_d;
    rv32i_types_pkg::regidx_t rs1_d, rd_d;
    rv32i_types_pkg::word_t imem_rdata, pc, decode_insn;
    logic iren, valid_decode, stall_queue, flush_queue;
    logic ex_mem_stall, ex_mem_flush, if_ex_flush, exc_valid;
    pipe_ctrl_pkg::exc_report_t exc;

    int errors;
    int checks;
    int test_errors;
    int tests_done;
    bit timed_out;

    pipeline_ctrl_top pipeline_ctrl_top_i (
        .clk, .rst_n, .imem_rdata, .i_mem_busy(1'b0), .d_mem_busy,
        .rs1_d, .rs2_d(5'd0), .rd_d, .reg_write_d, .dren_d, .dwen_d(1'b0), .csr_read_d(1'b0),
        .jump(1'b0), .branch, .mispredict, .branch_target(32'h0000_0400),
        .ex_busy(1'b0), .halt(1'b0), .fence_stall(1'b0), .ifence(1'b0),
        .fault_insn(1'b0), .mal_insn(1'b0), .illegal_insn(1'b0), .fault_l, .mal_l(1'b0),
        .fault_s(1'b0), .mal_s(1'b0), .breakpoint(1'b0), .env(1'b0),
        .intr, .ret(1'b0), .insert_pc(1'b0), .priv_pc(32'h0000_0800), .badaddr(32'h0000_bad0),
        .pc, .iren, .decode_insn, .valid_decode, .stall_queue, .flush_queue,
        .ex_mem_stall, .ex_mem_flush, .if_ex_flush, .exc_valid, .exc
    );

    bind pipeline_ctrl_top tb_pipeline_ctrl_sva sva_i (
        .clk, .rst_n, .flush_queue, .stall_queue, .is_queue_full, .valid_decode,
        .ex_mem_stall, .ex_mem_flush, .if_ex_flush, .exc_valid, .pc
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    // polls in 100 ps steps, gives up after 100 ns
    task automatic wait_edge(input logic level, output bit ok);
        logic prev;
        int steps;
        ok = 1'b0;
        steps = 0;
        prev = clk;
        while (!ok && steps < 1000) begin
            #0.1;
            steps++;
            if (prev !== level && clk === level) ok = 1'b1;
            prev = clk;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input rv32i_types_pkg::word_t got,
                              input rv32i_types_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_exc(input pipe_ctrl_pkg::exc_report_t got,
                             input pipe_ctrl_pkg::exc_report_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("error at %0t ns: exc report %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic finish_test(input int num);
        $display("test %0d done, %0d errors", num, test_errors);
        tests_done++;
        test_errors = 0;
    endtask

    initial begin
        int fd, n, cur_test;
        int t, dbusy, br, mis, flt, irq, rs1, rd, rw, ld;
        int e_vd, e_sq, e_fq, e_ems, e_emf, e_iff, e_excv;
        logic [31:0] e_pc, e_epc;
        string line;
        bit ok;
        bit take_fetch;
        pipe_ctrl_pkg::exc_report_t exp_exc;
        rv32i_types_pkg::word_t fetched[$];     // pcs expected in the queue, head first

        errors = 0;
        checks = 0;
        test_errors = 0;
        tests_done = 0;
        timed_out = 1'b0;
        cur_test = -1;
        rst_n = 1'b1;
        d_mem_busy = 1'b0;
        branch = 1'b0;
        mispredict = 1'b0;
        fault_l = 1'b0;
        intr = 1'b0;
        rs1_d = '0;
        rd_d = '0;
        reg_write_d = 1'b0;
        dren_d = 1'b0;
        imem_rdata = 32'h0000_0013;     // nop
        #1 rst_n = 1'b0;
        for (int i = 0; i < 4 && !timed_out; i++) begin     // 4 reset cycles
            wait_edge(1'b1, ok);
            if (!ok) timed_out = 1'b1;
        end
        wait_edge(1'b0, ok);
        if (!ok) timed_out = 1'b1;
        rst_n = 1'b1;                   // first vector lands on this falling edge

        fd = $fopen("pipeline_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open pipeline_stimulus.txt");
            errors++;
        end
        while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        t, dbusy, br, mis, flt, irq, rs1, rd, rw, ld,
                        e_pc, e_vd, e_sq, e_fq, e_ems, e_emf, e_iff, e_excv, e_epc);
            if (n != 19) begin
                $display("stimulus line has %0d fields instead of 19", n);
                errors++;
                continue;
            end
            if (t != cur_test && cur_test >= 0) finish_test(cur_test);
            cur_test = t;
            d_mem_busy = dbusy[0];
            branch = br[0];
            mispredict = mis[0];
            fault_l = flt[0];
            intr = irq[0];
            rs1_d = rs1[4:0];
            rd_d = rd[4:0];
            reg_write_d = rw[0];
            dren_d = ld[0];
            imem_rdata = pc ^ 32'h0000_0013;    // insn tagged by its address
            #15;                                // settled, before the rising edge
            exp_exc = '0;
            exp_exc.fault_l = flt[0];
            exp_exc.epc = e_epc;
            exp_exc.badaddr = 32'h0000_bad0;
            check_word("pc", pc, e_pc);
            check_bit("iren", iren, 1'b1);
            check_bit("valid_decode", valid_decode, e_vd[0]);
            check_bit("stall_queue", stall_queue, e_sq[0]);
            check_bit("flush_queue", flush_queue, e_fq[0]);
            check_bit("ex_mem_stall", ex_mem_stall, e_ems[0]);
            check_bit("ex_mem_flush", ex_mem_flush, e_emf[0]);
            check_bit("if_ex_flush", if_ex_flush, e_iff[0]);
            check_bit("exc_valid", exc_valid, e_excv[0]);
            check_bit("suppress_data", pipeline_ctrl_top_i.hazard_i.suppress_data, flt[0]);
            check_exc(exc, exp_exc);
            if (fetched.size() != 0) begin
                check_word("decode_insn", decode_insn, fetched[0] ^ 32'h0000_0013);
            end
            // reference queue, steps at the coming rising edge
            if (e_fq[0]) begin
                fetched.delete();
            end else begin
                take_fetch = !e_iff[0] && (fetched.size() < `QUEUE_DEPTH);
                if (e_vd[0] && !e_sq[0] && fetched.size() != 0) fetched.delete(0);
                if (take_fetch) fetched.push_back(e_pc);
            end
            wait_edge(1'b0, ok);
            if (!ok) timed_out = 1'b1;
        end
        if (cur_test >= 0) finish_test(cur_test);
        if (fd != 0) $fclose(fd);
        if (timed_out) $display("timed out waiting for a clock edge");
        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
rv32i_types_pkg.sv
pipe_ctrl_pkg.sv
fetch_pc_unit.sv
fetch_queue.sv
stage_latch.sv
stage3_hazard_unit.sv
pipeline_ctrl_top.sv
tb_pipeline_ctrl_sva.sv
tb_pipeline_ctrl.sv

/* Bender.yml */
package:
  name: pipeline_ctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv32i_types_pkg.sv
      - pipe_ctrl_pkg.sv
      - fetch_pc_unit.sv
      - fetch_queue.sv
      - stage_latch.sv
      - stage3_hazard_unit.sv
      - pipeline_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pipeline_ctrl_sva.sv
      - tb_pipeline_ctrl.sv

/* pipeline_stimulus.txt */
# test dbusy branch mispred fault_l intr rs1 rd reg_write dren
# then expected: pc valid_decode stall_queue flush_queue ex_mem_stall ex_mem_flush if_ex_flush exc_valid epc
1 0 0 0 0 0 00 00 0 0 00000200 0 0 0 0 0 0 0 00000200
1 0 0 0 0 0 00 00 0 0 00000204 1 0 0 0 0 0 0 00000200
2 0 0 0 0 0 00 05 1 1 00000208 1 0 0 0 0 0 0 00000200
2 0 0 0 0 0 05 00 0 0 0000020c 1 0 0 0 0 0 0 00000200
2 0 0 0 0 0 00 00 0 0 00000210 1 1 0 0 1 0 0 00000204
2 0 0 0 0 0 00 00 1 1 00000214 1 0 0 0 0 0 0 00000208
2 0 0 0 0 0 00 00 0 0 00000218 1 0 0 0 0 0 0 00000208
2 0 0 0 0 0 00 00 0 0 0000021c 1 0 0 0 0 0 0 0000020c
3 0 1 1 0 0 00 00 0 0 00000220 1 0 1 0 1 1 0 00000210
3 0 0 0 0 0 00 00 0 0 00000400 0 0 0 0 0 0 0 00000400
3 0 0 0 0 0 00 03 1 1 00000404 1 0 0 0 0 0 0 00000400
4 0 0 0 0 0 00 00 0 0 00000408 1 0 0 0 0 0 0 00000400
4 1 0 0 0 0 00 00 0 0 0000040c 1 1 0 1 0 0 0 00000400
4 1 0 0 0 0 00 00 0 0 00000410 1 1 0 1 0 0 0 00000400
4 1 0 0 0 0 00 00 0 0 00000414 1 1 0 1 0 0 0 00000400
4 1 0 0 0 0 00 00 0 0 00000418 1 1 0 1 0 0 0 00000400
4 1 0 0 0 0 00 00 0 0 00000418 1 1 0 1 0 0 0 00000400
4 0 0 0 0 0 00 00 0 0 00000418 1 0 0 0 0 0 0 00000400
5 0 0 0 1 0 00 00 0 0 00000418 1 0 1 0 1 1 1 00000404
5 0 0 0 1 0 00 00 0 0 0000041c 0 0 1 0 1 1 1 0000041c
6 0 0 0 0 0 00 00 0 0 00000420 0 0 0 0 0 0 0 00000420
6 0 0 0 0 0 00 07 1 1 00000424 1 0 0 0 0 0 0 00000420
6 0 0 0 0 0 00 00 0 0 00000428 1 0 0 0 0 0 0 00000420
6 1 0 0 0 1 00 00 0 0 0000042c 1 1 0 1 0 0 0 00000424
6 0 0 0 0 1 00 00 0 0 00000430 1 0 1 0 1 1 1 00000424
6 0 0 0 0 0 00 00 0 0 00000434 0 0 0 0 0 0 0 00000434
6 0 0 0 0 1 00 00 0 0 00000438 1 0 1 0 1 1 1 00000434
